// ==== sim.f ====
src/fft_cfg_pkg.sv
src/fft_regs_pkg.sv
src/cp_cfg_if.sv
src/fft_ctrl_regs.sv
src/fft_reset_gen.sv
src/cp_rem_list.sv
src/cp_remover.sv
src/fft_core_top.sv
tb/fft_core_checker.sv
tb/tb_fft_core.sv

// ==== tb/tb_fft_core.sv ====
// One sample per clock at most; each table row with prefixes clears the list first
`timescale 1ns/100ps

module tb_fft_core;

  logic                                ce_clk;
  logic                                ce_rst;
  logic                                i_ctrl_wr;
  logic                                i_ctrl_rd;
  logic [fft_regs_pkg::REG_ADDR_W-1:0] i_ctrl_addr;
  logic [fft_regs_pkg::REG_DATA_W-1:0] i_ctrl_data;
  logic                                o_ctrl_ack;
  logic [fft_regs_pkg::REG_DATA_W-1:0] o_ctrl_data;
  logic                                i_valid;
  fft_cfg_pkg::sample_t                i_data;
  logic                                o_valid;
  fft_cfg_pkg::sample_t                o_data;
  logic                                o_last;

  // Test table, one entry per row
  string row_name [6];
  int    row_size [6];
  int    row_nlens [6];
  int    row_len [6][3];
  bit    row_clear [6];
  bit    row_bypass [6];
  int    row_syms [6];
  bit    row_urst [6];
  int    row_occ [6];
  int    n_rows;

  fft_core_top dut (
    .ce_clk     (ce_clk     ),
    .ce_rst     (ce_rst     ),
    .i_ctrl_wr  (i_ctrl_wr  ),
    .i_ctrl_rd  (i_ctrl_rd  ),
    .i_ctrl_addr(i_ctrl_addr),
    .i_ctrl_data(i_ctrl_data),
    .o_ctrl_ack (o_ctrl_ack ),
    .o_ctrl_data(o_ctrl_data),
    .i_valid    (i_valid    ),
    .i_data     (i_data     ),
    .o_valid    (o_valid    ),
    .o_data     (o_data     ),
    .o_last     (o_last     )
  );

  fft_core_checker u_checker (
    .ce_clk      (ce_clk     ),
    .i_ctrl_wr   (i_ctrl_wr  ),
    .i_ctrl_rd   (i_ctrl_rd  ),
    .i_ctrl_addr (i_ctrl_addr),
    .i_ctrl_ack  (o_ctrl_ack ),
    .i_ctrl_rdata(o_ctrl_data),
    .i_in_valid  (i_valid    ),
    .i_in_data   (i_data     ),
    .i_out_valid (o_valid    ),
    .i_out_data  (o_data     ),
    .i_out_last  (o_last     )
  );

  // 100 ns period
  initial begin
    ce_clk = 1'b0;
    forever #50 ce_clk = ~ce_clk;
  end

  // --------------------
  // Table and helpers
  // --------------------
  task automatic add_row(input string name, input int size, input int nlens,
                         input int l0, input int l1, input int l2, input bit clr,
                         input bit byp, input int syms, input bit urst, input int occ);
    row_name[n_rows]   = name;
    row_size[n_rows]   = size;
    row_nlens[n_rows]  = nlens;
    row_len[n_rows][0] = l0;
    row_len[n_rows][1] = l1;
    row_len[n_rows][2] = l2;
    row_clear[n_rows]  = clr;
    row_bypass[n_rows] = byp;
    row_syms[n_rows]   = syms;
    row_urst[n_rows]   = urst;
    row_occ[n_rows]    = occ;
    n_rows++;
  endtask

  // Prefix plus body per symbol, one sample per symbol in bypass
  function automatic int row_samples(input int r);
    int total;
    total = 0;
    for (int s = 0; s < row_syms[r]; s++) begin
      if (row_bypass[r]) begin
        total += 1;
      end else if (row_nlens[r] == 0) begin
        total += 1 << row_size[r];
      end else begin
        total += row_len[r][s % row_nlens[r]] + (1 << row_size[r]);
      end
    end
    return total;
  endfunction

  // All bus tasks start and end 10 ns after a rising edge
  task automatic reg_write(input logic [19:0] addr, input logic [31:0] data);
    i_ctrl_wr   = 1'b1;
    i_ctrl_addr = addr;
    i_ctrl_data = data;
    @(posedge ce_clk);
    #10;
    i_ctrl_wr = 1'b0;
    @(posedge ce_clk);
    #10;
  endtask

  task automatic reg_read(input logic [19:0] addr, input logic [31:0] expected);
    u_checker.expect_read(expected);
    i_ctrl_rd   = 1'b1;
    i_ctrl_addr = addr;
    @(posedge ce_clk);
    #10;
    i_ctrl_rd = 1'b0;
    @(posedge ce_clk);
    #10;
  endtask

  // Core reset outlasts its trigger by 8 cycles plus register stages
  task automatic wait_reset_release();
    repeat (fft_cfg_pkg::RESET_PULSE_LEN + 6) @(posedge ce_clk);
    #10;
  endtask

  task automatic read_defaults();
    reg_read(fft_regs_pkg::REG_COMPAT_ADDR, 32'h0001_0000);
    reg_read(fft_regs_pkg::REG_CAPABILITIES_ADDR, 32'h0000_0306);
    reg_read(fft_regs_pkg::REG_LENGTH_LOG2_ADDR, 32'd6);
    reg_read(fft_regs_pkg::REG_CP_REM_LEN_ADDR, 32'd0);
    reg_read(fft_regs_pkg::REG_CP_REM_LIST_OCC_ADDR, 32'd0);
    reg_read(fft_regs_pkg::REG_BYPASS_ADDR, 32'd0);
    // Unmapped word
    reg_read(20'h40, 32'h0BAD_C0DE);
  endtask

  task automatic configure_row(input int r);
    if (row_clear[r]) begin
      reg_write(fft_regs_pkg::REG_CP_REM_LIST_CLR_ADDR, 32'd0);
      u_checker.clear_list();
    end
    reg_write(fft_regs_pkg::REG_LENGTH_LOG2_ADDR, row_size[r]);
    for (int k = 0; k < row_nlens[r]; k++) begin
      reg_write(fft_regs_pkg::REG_CP_REM_LEN_ADDR, row_len[r][k]);
      reg_write(fft_regs_pkg::REG_CP_REM_LIST_LOAD_ADDR, 32'd0);
      u_checker.load_len(row_len[r][k]);
    end
    reg_write(fft_regs_pkg::REG_BYPASS_ADDR, row_bypass[r]);
    u_checker.set_frame(row_size[r], row_bypass[r]);
    reg_read(fft_regs_pkg::REG_CP_REM_LIST_OCC_ADDR, row_occ[r]);
  endtask

  // Random samples, roughly one idle cycle in four
  task automatic stream_samples(input int count);
    int sent;
    sent = 0;
    while (sent < count) begin
      if (($urandom % 4) == 0) begin
        i_valid = 1'b0;
      end else begin
        i_valid = 1'b1;
        i_data  = $urandom;
        sent++;
      end
      @(posedge ce_clk);
      #10;
    end
    i_valid = 1'b0;
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int seed;
    int dummy;
    int total;
    int wd_cycles;
    int errs_before;
    int failed_tests;
    seed         = 20;
    dummy        = $urandom(seed);
    ce_rst       = 1'b1;
    i_ctrl_wr    = 1'b0;
    i_ctrl_rd    = 1'b0;
    i_ctrl_addr  = '0;
    i_ctrl_data  = '0;
    i_valid      = 1'b0;
    i_data       = '0;
    n_rows       = 0;
    failed_tests = 0;

    //       name          N  n  l0 l1 l2 clr byp syms urst occ
    add_row("defaults",    6, 0, 0, 0, 0, 0,  0,  0,   0,   0);
    add_row("cp5_n16",     4, 1, 5, 0, 0, 1,  0,  3,   0,   1);
    add_row("cp_cycle",    3, 3, 3, 0, 7, 1,  0,  5,   0,   3);
    add_row("cleared",     3, 0, 0, 0, 0, 1,  0,  4,   0,   0);
    add_row("bypass",      3, 1, 4, 0, 0, 1,  1,  20,  0,   1);
    add_row("user_reset",  6, 0, 0, 0, 0, 0,  0,  2,   1,   0);

    // Watchdog sized from the table
    total = 0;
    for (int r = 0; r < n_rows; r++) begin
      total += row_samples(r);
    end
    wd_cycles = 2 * total + 200;
    fork
      begin
        #(wd_cycles * 100);
        $display("Error: run did not finish within %0d cycles", wd_cycles);
        $display("Finished with errors");
        $finish;
      end
    join_none

    repeat (3) @(posedge ce_clk);
    #10;
    ce_rst = 1'b0;
    wait_reset_release();

    for (int r = 0; r < n_rows; r++) begin
      errs_before = u_checker.errors;
      if (row_urst[r]) begin
        reg_write(fft_regs_pkg::REG_RESET_ADDR, 32'd1);
        wait_reset_release();
        u_checker.reset_model();
      end
      if (row_syms[r] == 0 || row_urst[r]) begin
        read_defaults();
      end else begin
        configure_row(r);
      end
      if (row_syms[r] > 0) begin
        stream_samples(row_samples(r));
        // Let the last output drain
        repeat (3) @(posedge ce_clk);
        #10;
        reg_read(fft_regs_pkg::REG_CP_REM_LIST_OCC_ADDR, row_occ[r]);
      end
      u_checker.end_test();
      if (u_checker.errors != errs_before) begin
        failed_tests++;
      end
      $display("test %0d %s: %0d error(s)", r, row_name[r], u_checker.errors - errs_before);
    end

    $display("tests run %0d, tests with errors %0d, total errors %0d",
             n_rows, failed_tests, u_checker.errors);
    if (u_checker.errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : tb_fft_core

// ==== tb/fft_core_checker.sv ====
// Sees DUT ports only; its list model assumes a load never meets a pop in the same cycle
`timescale 1ns/100ps

module fft_core_checker (
  input logic                                ce_clk,
  // Register port at the DUT
  input logic                                i_ctrl_wr,
  input logic                                i_ctrl_rd,
  input logic [fft_regs_pkg::REG_ADDR_W-1:0] i_ctrl_addr,
  input logic                                i_ctrl_ack,
  input logic [fft_regs_pkg::REG_DATA_W-1:0] i_ctrl_rdata,
  // Sample stream in and out
  input logic                                i_in_valid,
  input fft_cfg_pkg::sample_t                i_in_data,
  input logic                                i_out_valid,
  input fft_cfg_pkg::sample_t                i_out_data,
  input logic                                i_out_last
);

  int                   errors;
  int                   cycle;
  logic [31:0]          rd_expect;
  // Request seen one cycle earlier
  bit                   req_d;
  bit                   rd_d;
  logic [19:0]          addr_d;
  logic [31:0]          exp_d;
  // Expected settings and prefix list
  int                   cfg_size;
  bit                   cfg_bypass;
  int                   len_list [$];
  // Framing position
  bit                   at_start;
  int                   p_left;
  int                   n_left;
  // Outputs still owed by the DUT
  fft_cfg_pkg::sample_t exp_data_q [$];
  bit                   exp_last_q [$];
  int                   exp_due_q [$];

  // --------------------
  // Calls from the testbench
  // --------------------
  task expect_read(input logic [31:0] value);
    rd_expect = value;
  endtask

  // Core reset state, default size 64, no bypass
  task reset_model();
    cfg_size   = 6;
    cfg_bypass = 1'b0;
    len_list.delete();
    at_start   = 1'b1;
    p_left     = 0;
    n_left     = 0;
  endtask

  task clear_list();
    len_list.delete();
  endtask

  // Push to a full list is lost
  task load_len(input int value);
    if (len_list.size() < 2**fft_cfg_pkg::CP_LIST_LEN_LOG2) begin
      len_list.push_back(value);
    end
  endtask

  task set_frame(input int size_log2, input bit bypass);
    cfg_size   = size_log2;
    cfg_bypass = bypass;
  endtask

  task end_test();
    if (exp_data_q.size() != 0) begin
      errors++;
      $display("Error: %0d expected output sample(s) never appeared", exp_data_q.size());
      exp_data_q.delete();
      exp_last_q.delete();
      exp_due_q.delete();
    end
  endtask

  initial begin
    errors    = 0;
    cycle     = 0;
    req_d     = 1'b0;
    rd_d      = 1'b0;
    rd_expect = '0;
    reset_model();
  end

  // --------------------
  // Per-cycle compare
  // --------------------
  // Mid-cycle sampling, inputs and registered outputs are both settled
  always @(negedge ce_clk) begin
    cycle++;
    // Ack owed for last cycle's request
    if (req_d) begin
      if (i_ctrl_ack !== 1'b1) begin
        errors++;
        $display("CHECK FAILED o_ctrl_ack addr 0x%05h: expected 0x1 actual 0x%0h",
                 addr_d, i_ctrl_ack);
      end else if (rd_d && (i_ctrl_rdata !== exp_d)) begin
        errors++;
        $display("CHECK FAILED o_ctrl_data addr 0x%05h: expected 0x%08h actual 0x%08h",
                 addr_d, exp_d, i_ctrl_rdata);
      end
    end else if (i_ctrl_ack === 1'b1) begin
      errors++;
      $display("Error: register acknowledge with no request one cycle before");
    end
    req_d  = (i_ctrl_wr === 1'b1) || (i_ctrl_rd === 1'b1);
    rd_d   = (i_ctrl_rd === 1'b1);
    addr_d = i_ctrl_addr;
    exp_d  = rd_expect;

    // Output side first, then model this cycle's input
    if (i_out_valid === 1'b1) begin
      if (exp_data_q.size() == 0) begin
        errors++;
        $display("Error: output strobe with no sample expected, data 0x%08h", i_out_data);
      end else begin
        if (exp_due_q[0] != cycle) begin
          errors++;
          $display("Error: output sample arrived %0d cycle(s) off its slot",
                   cycle - exp_due_q[0]);
        end
        if (i_out_data !== exp_data_q[0]) begin
          errors++;
          $display("CHECK FAILED o_data: expected 0x%08h actual 0x%08h",
                   exp_data_q[0], i_out_data);
        end
        if (i_out_last !== exp_last_q[0]) begin
          errors++;
          $display("CHECK FAILED o_last: expected 0x%0h actual 0x%0h",
                   exp_last_q[0], i_out_last);
        end
        void'(exp_data_q.pop_front());
        void'(exp_last_q.pop_front());
        void'(exp_due_q.pop_front());
      end
    end

    if (i_in_valid === 1'b1) begin
      if (at_start && cfg_bypass) begin
        // Own symbol, list untouched
        exp_data_q.push_back(i_in_data);
        exp_last_q.push_back(1'b0);
        exp_due_q.push_back(cycle + 1);
      end else begin
        if (at_start) begin
          // Pop and replay head, empty list means no prefix
          p_left = 0;
          if (len_list.size() > 0) begin
            p_left = len_list.pop_front();
            len_list.push_back(p_left);
          end
          n_left   = 1 << cfg_size;
          at_start = 1'b0;
        end
        if (p_left > 0) begin
          p_left--;
        end else begin
          n_left--;
          exp_data_q.push_back(i_in_data);
          exp_last_q.push_back(n_left == 0);
          exp_due_q.push_back(cycle + 1);
          at_start = (n_left == 0);
        end
      end
    end
  end

endmodule : fft_core_checker

// ==== src/fft_core_top.sv ====
// Register port is dead during the 8-cycle core reset; requests made then get no ack
`timescale 1ns/100ps

module fft_core_top (
  input  logic                                ce_clk,
  input  logic                                ce_rst,
  // Register port
  input  logic                                i_ctrl_wr,
  input  logic                                i_ctrl_rd,
  input  logic [fft_regs_pkg::REG_ADDR_W-1:0] i_ctrl_addr,
  input  logic [fft_regs_pkg::REG_DATA_W-1:0] i_ctrl_data,
  output logic                                o_ctrl_ack,
  output logic [fft_regs_pkg::REG_DATA_W-1:0] o_ctrl_data,
  // Sample stream
  input  logic                                i_valid,
  input  fft_cfg_pkg::sample_t                i_data,
  output logic                                o_valid,
  output fft_cfg_pkg::sample_t                o_data,
  output logic                                o_last
);

  logic                        core_rst;
  logic                        user_reset;
  fft_cfg_pkg::fft_size_log2_t fft_size_log2;
  logic                        bypass;
  fft_cfg_pkg::cp_len_t        cp_head;
  logic                        cp_head_valid;
  logic                        cp_pop;

  // Settings and list commands
  cp_cfg_if cp_cfg ();

  // --------------------
  // Control
  // --------------------
  fft_ctrl_regs u_regs (
    .i_clk          (ce_clk       ),
    .i_rst          (core_rst     ),
    .i_ctrl_wr      (i_ctrl_wr    ),
    .i_ctrl_rd      (i_ctrl_rd    ),
    .i_ctrl_addr    (i_ctrl_addr  ),
    .i_ctrl_data    (i_ctrl_data  ),
    .o_ctrl_ack     (o_ctrl_ack   ),
    .o_ctrl_data    (o_ctrl_data  ),
    .cfg            (cp_cfg.regs  ),
    .o_fft_size_log2(fft_size_log2),
    .o_bypass       (bypass       ),
    .o_user_reset   (user_reset   )
  );

  // Generator runs from the board reset, everything else from its output
  fft_reset_gen u_reset (
    .i_clk       (ce_clk    ),
    .i_rst       (ce_rst    ),
    .i_user_reset(user_reset),
    .o_core_rst  (core_rst  )
  );

  cp_rem_list u_list (
    .i_clk       (ce_clk       ),
    .i_rst       (core_rst     ),
    .cfg         (cp_cfg.list  ),
    .o_head      (cp_head      ),
    .o_head_valid(cp_head_valid),
    .i_pop       (cp_pop       )
  );

  // --------------------
  // Datapath
  // --------------------
  cp_remover u_remover (
    .i_clk          (ce_clk       ),
    .i_rst          (core_rst     ),
    .i_valid        (i_valid      ),
    .i_data         (i_data       ),
    .i_fft_size_log2(fft_size_log2),
    .i_bypass       (bypass       ),
    .i_head         (cp_head      ),
    .i_head_valid   (cp_head_valid),
    .o_pop          (cp_pop       ),
    .o_valid        (o_valid      ),
    .o_data         (o_data       ),
    .o_last         (o_last       )
  );

endmodule : fft_core_top

// ==== src/cp_remover.sv ====
// No back-pressure; kept samples come out one cycle after their strobe, dropped ones never
`timescale 1ns/100ps

module cp_remover (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_valid,
  input  fft_cfg_pkg::sample_t        i_data,
  input  fft_cfg_pkg::fft_size_log2_t i_fft_size_log2,
  input  logic                        i_bypass,
  input  fft_cfg_pkg::cp_len_t        i_head,
  input  logic                        i_head_valid,
  output logic                        o_pop,
  output logic                        o_valid,
  output fft_cfg_pkg::sample_t        o_data,
  output logic                        o_last
);

  fft_cfg_pkg::rem_state_e                  state;
  // Samples seen so far in the current phase
  logic [fft_cfg_pkg::MAX_FFT_SIZE_LOG2:0]  cnt;
  // Index of the last body sample, N-1
  logic [fft_cfg_pkg::MAX_FFT_SIZE_LOG2:0]  last_idx;
  logic [fft_cfg_pkg::MAX_FFT_SIZE_LOG2:0]  new_last_idx;
  fft_cfg_pkg::cp_len_t                     cp_len;
  fft_cfg_pkg::cp_len_t                     new_cp_len;
  logic                                     at_start;

  // Prefix phase with nothing counted is a symbol boundary
  assign at_start = (state == fft_cfg_pkg::S_PREFIX) && (cnt == '0);

  // Bypass makes every sample its own symbol, list untouched
  assign o_pop = i_valid && at_start && !i_bypass;

  // Empty list means no prefix
  assign new_cp_len   = i_head_valid ? i_head : '0;
  // 2**size - 1 as a low-bit mask
  assign new_last_idx = ~({(fft_cfg_pkg::MAX_FFT_SIZE_LOG2+1){1'b1}} << i_fft_size_log2);

  always_ff @(posedge i_clk) begin
    o_valid <= 1'b0;
    o_last  <= 1'b0;

    if (i_valid) begin
      o_data <= i_data;
      if (at_start) begin
        // --------------------
        // Symbol start
        // --------------------
        cp_len   <= new_cp_len;
        last_idx <= new_last_idx;
        if (i_bypass) begin
          o_valid <= 1'b1;
        end else if (new_cp_len != '0) begin
          // First prefix sample dropped here
          if (new_cp_len == fft_cfg_pkg::cp_len_t'(1)) begin
            state <= fft_cfg_pkg::S_BODY;
          end else begin
            cnt <= 1'b1;
          end
        end else begin
          // No prefix, sample opens the body
          o_valid <= 1'b1;
          if (new_last_idx == '0) begin
            o_last <= 1'b1;
          end else begin
            state <= fft_cfg_pkg::S_BODY;
            cnt   <= 1'b1;
          end
        end
      end else if (state == fft_cfg_pkg::S_PREFIX) begin
        // Dropping the rest of the prefix
        if ((cnt + 1'b1) == {1'b0, cp_len}) begin
          state <= fft_cfg_pkg::S_BODY;
          cnt   <= '0;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end else begin
        // Body sample passes
        o_valid <= 1'b1;
        if (cnt == last_idx) begin
          o_last <= 1'b1;
          state  <= fft_cfg_pkg::S_PREFIX;
          cnt    <= '0;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end

    if (i_rst) begin
      state   <= fft_cfg_pkg::S_PREFIX;
      cnt     <= '0;
      o_valid <= 1'b0;
      o_last  <= 1'b0;
    end
  end

  // Last marker never appears on an empty cycle
  a_last_with_valid : assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_last |-> o_valid
  );

endmodule : cp_remover

// ==== src/cp_rem_list.sv ====
// Loads to a full list and loads that collide with a replaying pop are dropped
`timescale 1ns/100ps

module cp_rem_list (
  input  logic                 i_clk,
  input  logic                 i_rst,
  cp_cfg_if.list               cfg,
  output fft_cfg_pkg::cp_len_t o_head,
  output logic                 o_head_valid,
  input  logic                 i_pop
);

  fft_cfg_pkg::cp_len_t                     mem [2**fft_cfg_pkg::CP_LIST_LEN_LOG2];
  logic [fft_cfg_pkg::CP_LIST_LEN_LOG2-1:0] rd_ptr;
  logic [fft_cfg_pkg::CP_LIST_LEN_LOG2-1:0] wr_ptr;
  fft_cfg_pkg::cp_occ_t                     occ;
  logic                                     full;
  logic                                     pop_en;
  logic                                     rotate;
  logic                                     drop_en;
  logic                                     push_en;
  fft_cfg_pkg::cp_len_t                     wr_data;

  // Top occupancy bit is set only at 8 entries
  assign full         = occ[fft_cfg_pkg::CP_LIST_LEN_LOG2];
  assign o_head       = mem[rd_ptr];
  assign o_head_valid = (occ != '0);
  assign cfg.occupied = occ;

  // Pop on an empty list does nothing
  assign pop_en  = i_pop && o_head_valid;
  // Replay moves head to tail, count unchanged
  assign rotate  = pop_en && fft_cfg_pkg::CP_REM_REPEAT;
  assign drop_en = pop_en && !rotate;
  // Single write port is shared with the replay
  assign push_en = cfg.load && !full && !rotate;
  assign wr_data = rotate ? o_head : cfg.cp_len;

  // --------------------
  // Storage
  // --------------------
  always_ff @(posedge i_clk) begin
    if ((rotate || push_en) && !cfg.clr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_rst || cfg.clr) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      occ    <= '0;
    end else begin
      if (rotate || push_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_en && !drop_en) begin
        occ <= occ + 1'b1;
      end else if (drop_en && !push_en) begin
        occ <= occ - 1'b1;
      end
    end
  end

  a_occ_bound : assert property (
    @(posedge i_clk) disable iff (i_rst)
    occ <= fft_cfg_pkg::cp_occ_t'(2**fft_cfg_pkg::CP_LIST_LEN_LOG2)
  );

endmodule : cp_rem_list

// ==== src/fft_reset_gen.sv ====
// i_rst is the board reset; core reset stays high 8 cycles after it or after a user request
`timescale 1ns/100ps

module fft_reset_gen (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_user_reset,
  output logic o_core_rst
);

  fft_cfg_pkg::reset_state_e                       state;
  logic [$clog2(fft_cfg_pkg::RESET_PULSE_LEN)-1:0] cnt;
  logic                                            user_rst;

  always_ff @(posedge i_clk) begin
    // Registered so the core reset is glitch free
    o_core_rst <= user_rst | i_rst;

    case (state)
      fft_cfg_pkg::S_RESET_IDLE: begin
        cnt <= '0;
        if (i_user_reset) begin
          user_rst <= 1'b1;
          state    <= fft_cfg_pkg::S_RESET_ASSERT;
        end
      end
      fft_cfg_pkg::S_RESET_ASSERT: begin
        // Hold for the full pulse length, then release
        if (int'(cnt) == fft_cfg_pkg::RESET_PULSE_LEN - 1) begin
          cnt      <= '0;
          user_rst <= 1'b0;
          state    <= fft_cfg_pkg::S_RESET_IDLE;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
      default: state <= fft_cfg_pkg::S_RESET_IDLE;
    endcase

    // Board reset restarts the stretch
    if (i_rst) begin
      cnt      <= '0;
      user_rst <= 1'b1;
      state    <= fft_cfg_pkg::S_RESET_ASSERT;
    end
  end

endmodule : fft_reset_gen

// ==== src/fft_ctrl_regs.sv ====
// Ack one cycle after each request and none during reset; size writes saturate to 3..6
`timescale 1ns/100ps

module fft_ctrl_regs (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic                                i_ctrl_wr,
  input  logic                                i_ctrl_rd,
  input  logic [fft_regs_pkg::REG_ADDR_W-1:0] i_ctrl_addr,
  input  logic [fft_regs_pkg::REG_DATA_W-1:0] i_ctrl_data,
  output logic                                o_ctrl_ack,
  output logic [fft_regs_pkg::REG_DATA_W-1:0] o_ctrl_data,
  cp_cfg_if.regs                              cfg,
  output fft_cfg_pkg::fft_size_log2_t         o_fft_size_log2,
  output logic                                o_bypass,
  output logic                                o_user_reset
);

  logic [fft_regs_pkg::REG_ADDR_W-1:0]        addr;
  logic [fft_regs_pkg::REG_LENGTH_LOG2_W-1:0] wr_size;
  fft_cfg_pkg::fft_size_log2_t                size_sat;
  fft_cfg_pkg::cp_len_t                       reg_cp_len;

  // Word-aligned address with byte lanes ignored
  assign addr = {i_ctrl_addr[fft_regs_pkg::REG_ADDR_W-1:2], 2'b00};

  // Staged prefix length feeds the list directly
  assign cfg.cp_len = reg_cp_len;

  // --------------------
  // Size saturation
  // --------------------
  always_comb begin
    wr_size = i_ctrl_data[fft_regs_pkg::REG_LENGTH_LOG2_W-1:0];
    if (wr_size < fft_cfg_pkg::MIN_FFT_SIZE_LOG2) begin
      size_sat = fft_cfg_pkg::fft_size_log2_t'(fft_cfg_pkg::MIN_FFT_SIZE_LOG2);
    end else if (wr_size > fft_cfg_pkg::MAX_FFT_SIZE_LOG2) begin
      size_sat = fft_cfg_pkg::fft_size_log2_t'(fft_cfg_pkg::MAX_FFT_SIZE_LOG2);
    end else begin
      size_sat = wr_size;
    end
  end

  // --------------------
  // Register access
  // --------------------
  always_ff @(posedge i_clk) begin
    // Strobes last one cycle
    o_user_reset <= 1'b0;
    cfg.load     <= 1'b0;
    cfg.clr      <= 1'b0;
    // Every request gets an ack whether mapped or not
    o_ctrl_ack   <= i_ctrl_wr | i_ctrl_rd;

    if (i_ctrl_rd) begin
      case (addr)
        fft_regs_pkg::REG_COMPAT_ADDR:
          o_ctrl_data <= fft_regs_pkg::COMPAT_VALUE;
        fft_regs_pkg::REG_CAPABILITIES_ADDR:
          o_ctrl_data <= fft_regs_pkg::CAPABILITIES_VALUE;
        fft_regs_pkg::REG_LENGTH_LOG2_ADDR:
          o_ctrl_data <= fft_regs_pkg::REG_DATA_W'(o_fft_size_log2);
        fft_regs_pkg::REG_CP_REM_LEN_ADDR:
          o_ctrl_data <= fft_regs_pkg::REG_DATA_W'(reg_cp_len);
        fft_regs_pkg::REG_CP_REM_LIST_OCC_ADDR:
          o_ctrl_data <= fft_regs_pkg::REG_DATA_W'(cfg.occupied);
        fft_regs_pkg::REG_BYPASS_ADDR:
          o_ctrl_data <= fft_regs_pkg::REG_DATA_W'(o_bypass);
        // Strobe-only and unmapped addresses
        default:
          o_ctrl_data <= fft_regs_pkg::BAD_ADDR_VALUE;
      endcase
    end

    if (i_ctrl_wr) begin
      case (addr)
        fft_regs_pkg::REG_RESET_ADDR:
          o_user_reset <= 1'b1;
        fft_regs_pkg::REG_LENGTH_LOG2_ADDR:
          o_fft_size_log2 <= size_sat;
        fft_regs_pkg::REG_CP_REM_LEN_ADDR:
          reg_cp_len <= i_ctrl_data[fft_regs_pkg::REG_CP_REM_LEN_W-1:0];
        fft_regs_pkg::REG_CP_REM_LIST_LOAD_ADDR:
          cfg.load <= 1'b1;
        fft_regs_pkg::REG_CP_REM_LIST_CLR_ADDR:
          cfg.clr <= 1'b1;
        fft_regs_pkg::REG_BYPASS_ADDR:
          o_bypass <= i_ctrl_data[fft_regs_pkg::REG_BYPASS_W-1:0];
        // Read-only and unmapped writes drop silently
        default: ;
      endcase
    end

    if (i_rst) begin
      o_ctrl_ack      <= 1'b0;
      o_user_reset    <= 1'b0;
      cfg.load        <= 1'b0;
      cfg.clr         <= 1'b0;
      o_fft_size_log2 <= fft_cfg_pkg::fft_size_log2_t'(fft_regs_pkg::DEFAULT_FFT_SIZE_LOG2);
      reg_cp_len      <= fft_cfg_pkg::cp_len_t'(fft_regs_pkg::DEFAULT_CP_LEN);
      o_bypass        <= fft_regs_pkg::DEFAULT_BYPASS;
    end
  end

  // Ack only follows a request that was a read or a write but not both
  a_ack_follows_req : assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_ctrl_ack |-> $past(i_ctrl_wr ^ i_ctrl_rd)
  );

endmodule : fft_ctrl_regs

// ==== src/cp_cfg_if.sv ====
// Strobes are one cycle wide; occupied is the live entry count of the prefix list
`timescale 1ns/100ps

interface cp_cfg_if;

  // Prefix length to push on load
  fft_cfg_pkg::cp_len_t cp_len;
  // One-cycle push and clear strobes
  logic                 load;
  logic                 clr;
  // Entry count, 0 to 8
  fft_cfg_pkg::cp_occ_t occupied;

  // Register bank side
  modport regs (output cp_len, output load, output clr, input occupied);

  // Prefix list side
  modport list (input cp_len, input load, input clr, output occupied);

endinterface : cp_cfg_if

// ==== src/fft_regs_pkg.sv ====
// Byte addresses with the low two bits ignored; unmapped reads return 0x0BADC0DE
package fft_regs_pkg;

  // --------------------
  // Port widths
  // --------------------
  localparam int REG_ADDR_W = 20;
  localparam int REG_DATA_W = 32;

  // --------------------
  // Register map
  // --------------------
  localparam logic [REG_ADDR_W-1:0] REG_COMPAT_ADDR           = 20'h00;
  localparam logic [REG_ADDR_W-1:0] REG_CAPABILITIES_ADDR     = 20'h04;
  localparam logic [REG_ADDR_W-1:0] REG_RESET_ADDR            = 20'h08;
  localparam logic [REG_ADDR_W-1:0] REG_LENGTH_LOG2_ADDR      = 20'h0C;
  localparam logic [REG_ADDR_W-1:0] REG_CP_REM_LEN_ADDR       = 20'h10;
  localparam logic [REG_ADDR_W-1:0] REG_CP_REM_LIST_LOAD_ADDR = 20'h14;
  localparam logic [REG_ADDR_W-1:0] REG_CP_REM_LIST_CLR_ADDR  = 20'h18;
  localparam logic [REG_ADDR_W-1:0] REG_CP_REM_LIST_OCC_ADDR  = 20'h1C;
  localparam logic [REG_ADDR_W-1:0] REG_BYPASS_ADDR           = 20'h20;

  // Field widths of the writable registers
  localparam int REG_LENGTH_LOG2_W = 3;
  localparam int REG_CP_REM_LEN_W  = fft_cfg_pkg::MAX_FFT_SIZE_LOG2;
  localparam int REG_BYPASS_W      = 1;

  // --------------------
  // Read-only values
  // --------------------
  localparam logic [REG_DATA_W-1:0] COMPAT_VALUE = 32'h0001_0000;
  // List depth exponent in 15:8, max FFT exponent in 7:0
  localparam logic [REG_DATA_W-1:0] CAPABILITIES_VALUE = {
    16'h0000,
    8'(fft_cfg_pkg::CP_LIST_LEN_LOG2),
    8'(fft_cfg_pkg::MAX_FFT_SIZE_LOG2)
  };
  localparam logic [REG_DATA_W-1:0] BAD_ADDR_VALUE = 32'h0BAD_C0DE;

  // Reset defaults
  localparam int DEFAULT_FFT_SIZE_LOG2 = 6;
  localparam int DEFAULT_CP_LEN        = 0;
  localparam bit DEFAULT_BYPASS        = 1'b0;

endpackage : fft_regs_pkg

// ==== src/fft_cfg_pkg.sv ====
// Single channel at one sample per clock; FFT sizes 8 to 64, prefix shorter than the FFT size
package fft_cfg_pkg;

  // --------------------
  // Sizing
  // --------------------

  // Largest FFT is 2**6 = 64 samples
  localparam int MAX_FFT_SIZE_LOG2 = 6;
  // Smallest FFT is 2**3 = 8 samples
  localparam int MIN_FFT_SIZE_LOG2 = 3;

  // Prefix list holds 2**3 = 8 entries
  localparam int CP_LIST_LEN_LOG2 = 3;
  // Popped entries go back to the tail, so the list replays
  localparam bit CP_REM_REPEAT = 1'b1;

  // Core reset length in cycles after a user request
  localparam int RESET_PULSE_LEN = 8;

  // Sample width, packed I/Q
  localparam int ITEM_W = 32;

  // --------------------
  // Datapath types
  // --------------------

  typedef logic [ITEM_W-1:0] sample_t;

  // Prefix length, at most the max FFT size minus one
  typedef logic [MAX_FFT_SIZE_LOG2-1:0] cp_len_t;

  // FFT size exponent
  typedef logic [2:0] fft_size_log2_t;

  // List occupancy, one extra bit so a full list reads as 8
  typedef logic [CP_LIST_LEN_LOG2:0] cp_occ_t;

  // Reset stretcher states
  typedef enum logic [0:0] {
    S_RESET_IDLE,
    S_RESET_ASSERT
  } reset_state_e;

  // Prefix remover states
  typedef enum logic [0:0] {
    S_PREFIX,
    S_BODY
  } rem_state_e;

endpackage : fft_cfg_pkg
